// File: hw/noc_alloc_macros.svh
`ifndef NOC_ALLOC_MACROS_SVH
`define NOC_ALLOC_MACROS_SVH

// router geometry
`define NOC_P 5
`define NOC_V 4

// legal destinations per input, a port never routes to itself
`define NOC_P_1 (`NOC_P - 1)

// input VCs over all ports
`define NOC_PV (`NOC_P * `NOC_V)

`endif

// File: hw/noc_alloc_pkg.sv
`include "noc_alloc_macros.svh"

package noc_alloc_pkg;

    // one bit per VC of a single port
    typedef logic [`NOC_V-1:0] port_vc_t;

    // destination relative to the input port, own port index skipped
    typedef logic [`NOC_P_1-1:0] out_sel_t;

    typedef logic [`NOC_P-1:0] port_bits_t;

    // port-major, VC k of port p sits at bit p*V+k
    typedef logic [`NOC_PV-1:0] all_vc_t;

    typedef logic [`NOC_PV*`NOC_P_1-1:0] dest_all_t;     // out_sel_t per input VC
    typedef logic [`NOC_P*`NOC_P_1-1:0] out_sel_all_t;   // out_sel_t per input port
    typedef logic [`NOC_PV*`NOC_V-1:0] cand_ovc_all_t;   // port_vc_t per input VC

endpackage

// File: hw/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    output logic [width-1:0] grant,
    output logic             any_grant
);

    logic [width-1:0]   priority_oh;    // one-hot, highest priority position
    logic [width-1:0]   priority_nxt;
    logic [2*width-1:0] double_req;
    logic [2*width-1:0] double_grant;

    // subtracting the pointer clears the first request at or above it,
    // the upper copy catches the wrap-around
    assign double_req   = {request, request};
    assign double_grant = double_req & ~(double_req - {{width{1'b0}}, priority_oh});
    assign grant        = double_grant[width-1:0] | double_grant[2*width-1:width];
    assign any_grant    = |request;

    // input right after the winner goes first next time
    assign priority_nxt = (grant << 1) | (grant >> (width - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priority_oh <= width'(1);   // index 0 favored
        end else if (any_grant) begin
            priority_oh <= priority_nxt;
        end
    end

    grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~request) == '0))
        else $error("rr_arbiter: grant not one-hot or not requested");

endmodule

// File: hw/one_hot_select.sv
`timescale 1ns/1ps

module one_hot_select #(
    parameter type payload_t = logic [7:0],
    parameter int  count     = 4
) (
    input  logic [count-1:0] sel,
    input  payload_t         payload_in [count],
    output payload_t         payload_out
);

    // and-or mux, zero select gives zero payload
    always_comb begin
        payload_out = '0;
        for (int i = 0; i < count; i++) begin
            if (sel[i]) begin
                payload_out = payload_out | payload_in[i];
            end
        end
    end

    // sel comes from an arbiter grant in the parent
    always_comb begin
        sel_onehot: assert final ($onehot0(sel))
            else $error("one_hot_select: more than one select bit set");
    end

endmodule

// File: hw/switch_alloc_stage.sv
`timescale 1ns/1ps
`include "noc_alloc_macros.svh"

module switch_alloc_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  noc_alloc_pkg::all_vc_t      eligible,
    input  noc_alloc_pkg::dest_all_t    dest_port,
    output noc_alloc_pkg::all_vc_t      ivc_grant,
    output noc_alloc_pkg::out_sel_all_t granted_dest_port,
    output noc_alloc_pkg::port_bits_t   inport_granted,
    output noc_alloc_pkg::port_bits_t   outport_granted
);

    import noc_alloc_pkg::*;

    port_vc_t            first_grant [`NOC_P];            // winning VC per input
    out_sel_t            vc_dest     [`NOC_P][`NOC_V];
    out_sel_t            req_dest    [`NOC_P];            // destination of that winner
    out_sel_t            won_dest    [`NOC_P];            // output that took the input
    logic [`NOC_P_1-1:0] out_req     [`NOC_P];            // one bit per other input
    logic [`NOC_P_1-1:0] out_grant   [`NOC_P];

    for (genvar i = 0; i < `NOC_P; i++) begin : g_in
        for (genvar v = 0; v < `NOC_V; v++) begin : g_vc
            assign vc_dest[i][v] = dest_port[(i*`NOC_V+v)*`NOC_P_1 +: `NOC_P_1];
        end

        // first level, one VC per input port
        rr_arbiter #(
            .width(`NOC_V)
        ) u_vc_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (eligible[i*`NOC_V +: `NOC_V]),
            .grant    (first_grant[i]),
            .any_grant()
        );

        one_hot_select #(
            .payload_t(out_sel_t),
            .count    (`NOC_V)
        ) u_dest_sel (
            .sel        (first_grant[i]),
            .payload_in (vc_dest[i]),
            .payload_out(req_dest[i])
        );

        assign inport_granted[i]                        = |won_dest[i];
        assign granted_dest_port[i*`NOC_P_1 +: `NOC_P_1] = won_dest[i];
        // VC only granted when its port also wins the output
        assign ivc_grant[i*`NOC_V +: `NOC_V] = inport_granted[i] ? first_grant[i] : '0;
    end

    // relative <-> absolute index mapping between inputs and outputs
    for (genvar o = 0; o < `NOC_P; o++) begin : g_out
        for (genvar p = 0; p < `NOC_P; p++) begin : g_src
            if (p < o) begin : g_below
                assign out_req[o][p]    = req_dest[p][o-1];
                assign won_dest[p][o-1] = out_grant[o][p];
            end else if (p > o) begin : g_above
                assign out_req[o][p-1] = req_dest[p][o];
                assign won_dest[p][o]  = out_grant[o][p-1];
            end
        end

        // second level, one input per output port
        rr_arbiter #(
            .width(`NOC_P_1)
        ) u_port_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (out_req[o]),
            .grant    (out_grant[o]),
            .any_grant(outport_granted[o])
        );
    end

endmodule

// File: hw/spec_switch_alloc.sv
`timescale 1ns/1ps
`include "noc_alloc_macros.svh"

module spec_switch_alloc (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_alloc_pkg::all_vc_t       ivc_request,
    input  noc_alloc_pkg::all_vc_t       ovc_is_assigned,
    input  noc_alloc_pkg::all_vc_t       assigned_ovc_not_full,
    input  noc_alloc_pkg::dest_all_t     dest_port,
    input  noc_alloc_pkg::cand_ovc_all_t candidate_ovc,
    output noc_alloc_pkg::all_vc_t       ivc_sw_grant,
    output noc_alloc_pkg::out_sel_all_t  granted_dest_port,
    output noc_alloc_pkg::port_bits_t    port_sw_granted,
    output noc_alloc_pkg::all_vc_t       spec_ivc_grant,
    output noc_alloc_pkg::out_sel_all_t  spec_dest_grant
);

    import noc_alloc_pkg::*;

    all_vc_t             cand_valid;        // some free OVC at the destination
    all_vc_t             nonspec_eligible;
    all_vc_t             spec_eligible;
    all_vc_t             nonspec_ivc_grant;
    all_vc_t             spec_ivc_pre;
    out_sel_all_t        nonspec_dest;
    out_sel_all_t        spec_dest_pre;
    port_bits_t          nonspec_inport;
    port_bits_t          nonspec_outport;
    port_bits_t          spec_inport_acc;
    port_bits_t          spec_outport_acc;
    out_sel_t            nonspec_out_rel  [`NOC_P];  // busy outputs seen from each input
    out_sel_t            spec_dest_ok     [`NOC_P];
    logic [`NOC_P_1-1:0] spec_out_hits    [`NOC_P];  // accepted spec inputs per output
    logic [`NOC_P_1-1:0] nonspec_out_hits [`NOC_P];  // non-spec inputs per output

    for (genvar k = 0; k < `NOC_PV; k++) begin : g_cand
        assign cand_valid[k] = |candidate_ovc[k*`NOC_V +: `NOC_V];
    end

    assign nonspec_eligible = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
    // unassigned VCs with nothing free never enter arbitration
    assign spec_eligible    = ivc_request & ~ovc_is_assigned & cand_valid;

    switch_alloc_stage u_nonspec (
        .clk              (clk),
        .rst_n            (rst_n),
        .eligible         (nonspec_eligible),
        .dest_port        (dest_port),
        .ivc_grant        (nonspec_ivc_grant),
        .granted_dest_port(nonspec_dest),
        .inport_granted   (nonspec_inport),
        .outport_granted  (nonspec_outport)
    );

    switch_alloc_stage u_spec (
        .clk              (clk),
        .rst_n            (rst_n),
        .eligible         (spec_eligible),
        .dest_port        (dest_port),
        .ivc_grant        (spec_ivc_pre),
        .granted_dest_port(spec_dest_pre),
        .inport_granted   (),
        .outport_granted  ()
    );

    for (genvar i = 0; i < `NOC_P; i++) begin : g_port
        for (genvar o = 0; o < `NOC_P; o++) begin : g_map
            if (o < i) begin : g_below
                assign nonspec_out_rel[i][o]    = nonspec_outport[o];
                assign spec_out_hits[o][i-1]    = spec_dest_ok[i][o];
                assign nonspec_out_hits[o][i-1] = nonspec_dest[i*`NOC_P_1 + o];
            end else if (o > i) begin : g_above
                assign nonspec_out_rel[i][o-1] = nonspec_outport[o];
                assign spec_out_hits[o][i]     = spec_dest_ok[i][o-1];
                assign nonspec_out_hits[o][i]  = nonspec_dest[i*`NOC_P_1 + o - 1];
            end
        end

        // non-spec grant on this input or on the target output kills the spec one
        assign spec_dest_ok[i] = nonspec_inport[i] ? '0 :
                                 spec_dest_pre[i*`NOC_P_1 +: `NOC_P_1] & ~nonspec_out_rel[i];

        assign spec_inport_acc[i]  = |spec_dest_ok[i];
        assign spec_outport_acc[i] = |spec_out_hits[i];

        assign spec_dest_grant[i*`NOC_P_1 +: `NOC_P_1] = spec_dest_ok[i];
        assign spec_ivc_grant[i*`NOC_V +: `NOC_V] =
            spec_inport_acc[i] ? spec_ivc_pre[i*`NOC_V +: `NOC_V] : '0;

        // port i as input by its VC grants, as output by the granted destinations
        classes_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
            !((|nonspec_ivc_grant[i*`NOC_V +: `NOC_V]) &&
              (|spec_ivc_grant[i*`NOC_V +: `NOC_V])) &&
            !((|nonspec_out_hits[i]) && spec_outport_acc[i]))
            else $error("spec_switch_alloc: port %0d granted by both classes", i);
    end

    assign ivc_sw_grant      = nonspec_ivc_grant | spec_ivc_grant;
    assign granted_dest_port = nonspec_dest | spec_dest_grant;
    assign port_sw_granted   = nonspec_inport | spec_inport_acc;

endmodule

// File: hw/vc_alloc_stage.sv
`timescale 1ns/1ps
`include "noc_alloc_macros.svh"

module vc_alloc_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_alloc_pkg::all_vc_t       spec_ivc_grant,
    input  noc_alloc_pkg::out_sel_all_t  spec_dest_grant,
    input  noc_alloc_pkg::cand_ovc_all_t candidate_ovc,
    output noc_alloc_pkg::all_vc_t       ivc_ovc_grant,
    output noc_alloc_pkg::port_vc_t      granted_ovc [`NOC_P],
    output noc_alloc_pkg::all_vc_t       ovc_allocated
);

    import noc_alloc_pkg::*;

    port_vc_t            vc_cand   [`NOC_P][`NOC_V];
    port_vc_t            win_cand  [`NOC_P];            // free OVCs of the spec winner
    port_bits_t          ovc_found;
    logic [`NOC_P_1-1:0] claim     [`NOC_P][`NOC_V];    // per output VC, one bit per input

    for (genvar i = 0; i < `NOC_P; i++) begin : g_in
        for (genvar v = 0; v < `NOC_V; v++) begin : g_vc
            assign vc_cand[i][v] = candidate_ovc[(i*`NOC_V+v)*`NOC_V +: `NOC_V];
        end

        // zero select when the port had no accepted spec grant
        one_hot_select #(
            .payload_t(port_vc_t),
            .count    (`NOC_V)
        ) u_cand_sel (
            .sel        (spec_ivc_grant[i*`NOC_V +: `NOC_V]),
            .payload_in (vc_cand[i]),
            .payload_out(win_cand[i])
        );

        rr_arbiter #(
            .width(`NOC_V)
        ) u_ovc_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (win_cand[i]),
            .grant    (granted_ovc[i]),
            .any_grant(ovc_found[i])
        );

        assign ivc_ovc_grant[i*`NOC_V +: `NOC_V] =
            ovc_found[i] ? spec_ivc_grant[i*`NOC_V +: `NOC_V] : '0;
    end

    // steer each picked OVC onto the output its input was granted
    for (genvar o = 0; o < `NOC_P; o++) begin : g_out
        for (genvar v = 0; v < `NOC_V; v++) begin : g_ovc
            for (genvar p = 0; p < `NOC_P; p++) begin : g_src
                if (p < o) begin : g_below
                    assign claim[o][v][p] =
                        spec_dest_grant[p*`NOC_P_1 + o - 1] & granted_ovc[p][v];
                end else if (p > o) begin : g_above
                    assign claim[o][v][p-1] =
                        spec_dest_grant[p*`NOC_P_1 + o] & granted_ovc[p][v];
                end
            end

            assign ovc_allocated[o*`NOC_V + v] = |claim[o][v];

            single_claim: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(claim[o][v]))
                else $error("vc_alloc_stage: output %0d VC %0d claimed twice", o, v);
        end
    end

endmodule

// File: hw/comb_spec_allocator.sv
`timescale 1ns/1ps
`include "noc_alloc_macros.svh"

module comb_spec_allocator (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_alloc_pkg::all_vc_t       ivc_request,
    input  noc_alloc_pkg::all_vc_t       ovc_is_assigned,
    input  noc_alloc_pkg::all_vc_t       assigned_ovc_not_full,
    input  noc_alloc_pkg::dest_all_t     dest_port,
    input  noc_alloc_pkg::cand_ovc_all_t candidate_ovc,
    output noc_alloc_pkg::all_vc_t       ivc_sw_grant,
    output noc_alloc_pkg::out_sel_all_t  granted_dest_port,
    output noc_alloc_pkg::port_bits_t    port_sw_granted,
    output noc_alloc_pkg::all_vc_t       ivc_ovc_grant,
    output noc_alloc_pkg::port_vc_t      granted_ovc [`NOC_P],
    output noc_alloc_pkg::all_vc_t       ovc_allocated
);

    import noc_alloc_pkg::*;

    all_vc_t      spec_ivc_grant;     // speculative winners that survived
    out_sel_all_t spec_dest_grant;

    spec_switch_alloc u_sw_alloc (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .candidate_ovc        (candidate_ovc),
        .ivc_sw_grant         (ivc_sw_grant),
        .granted_dest_port    (granted_dest_port),
        .port_sw_granted      (port_sw_granted),
        .spec_ivc_grant       (spec_ivc_grant),
        .spec_dest_grant      (spec_dest_grant)
    );

    // OVC pick happens in the same cycle as the switch grant
    vc_alloc_stage u_vc_alloc (
        .clk            (clk),
        .rst_n          (rst_n),
        .spec_ivc_grant (spec_ivc_grant),
        .spec_dest_grant(spec_dest_grant),
        .candidate_ovc  (candidate_ovc),
        .ivc_ovc_grant  (ivc_ovc_grant),
        .granted_ovc    (granted_ovc),
        .ovc_allocated  (ovc_allocated)
    );

endmodule

// File: verification/allocator_tests.svh
// one-hot destination as seen from input src with its own port skipped
function automatic out_sel_t rel_sel(input int src, input int dst);
    out_sel_t sel;
    sel = '0;
    sel[(dst < src) ? dst : dst - 1] = 1'b1;
    return sel;
endfunction

function automatic int abs_out(input int src, input int rel);
    return (rel < src) ? rel : rel + 1;
endfunction

function automatic all_vc_t vc_bit(input int p, input int v);
    return all_vc_t'(1) << (p * `NOC_V + v);
endfunction

function automatic out_sel_all_t dest_field(input int p, input out_sel_t sel);
    return out_sel_all_t'(sel) << (p * `NOC_P_1);
endfunction

function automatic all_vc_t flat_ovc();
    all_vc_t flat;
    for (int p = 0; p < `NOC_P; p++) begin
        flat[p*`NOC_V +: `NOC_V] = granted_ovc[p];
    end
    return flat;
endfunction

task automatic request_vc(input int p, input int v, input int dst, input logic assigned,
                          input logic not_full, input port_vc_t cand);
    int k;
    k = p * `NOC_V + v;
    ivc_request[k]                      = 1'b1;
    ovc_is_assigned[k]                  = assigned;
    assigned_ovc_not_full[k]            = not_full;
    dest_port[k*`NOC_P_1 +: `NOC_P_1]   = rel_sel(p, dst);
    candidate_ovc[k*`NOC_V +: `NOC_V]   = cand;
endtask

task automatic check_outputs(input all_vc_t sw, input out_sel_all_t dest,
                             input port_bits_t ports, input all_vc_t ovc_grant,
                             input all_vc_t picked, input all_vc_t alloc, input string what);
    check_value(ivc_sw_grant, sw, {what, ": ivc_sw_grant"});
    check_value(granted_dest_port, dest, {what, ": granted_dest_port"});
    check_value(port_sw_granted, ports, {what, ": port_sw_granted"});
    check_value(ivc_ovc_grant, ovc_grant, {what, ": ivc_ovc_grant"});
    check_value(flat_ovc(), picked, {what, ": granted_ovc"});
    check_value(ovc_allocated, alloc, {what, ": ovc_allocated"});
endtask

task automatic test_idle();
    reset_dut();
    settle();
    check_outputs('0, '0, '0, '0, '0, '0, "idle");
    next_slot();
    ovc_is_assigned       = '1;   // status alone must not grant
    assigned_ovc_not_full = '1;
    candidate_ovc         = '1;
    settle();
    check_outputs('0, '0, '0, '0, '0, '0, "idle with status set");
endtask

task automatic test_nonspec_grant();
    reset_dut();
    request_vc(1, 2, 3, 1'b1, 1'b1, '0);
    settle();
    check_outputs(vc_bit(1, 2), dest_field(1, rel_sel(1, 3)), port_bits_t'(1) << 1,
                  '0, '0, '0, "non-spec single");
    next_slot();
    assigned_ovc_not_full[1*`NOC_V+2] = 1'b0;
    settle();
    check_outputs('0, '0, '0, '0, '0, '0, "non-spec full");
endtask

task automatic test_spec_grant();
    reset_dut();
    request_vc(2, 0, 0, 1'b0, 1'b0, 4'b1010);
    settle();
    // ovc pointer sits at 0 after reset so VC 1 of output 0 wins
    check_outputs(vc_bit(2, 0), dest_field(2, rel_sel(2, 0)), port_bits_t'(1) << 2,
                  vc_bit(2, 0), vc_bit(2, 1), vc_bit(0, 1), "spec single");
    next_slot();
    candidate_ovc = '0;
    settle();
    check_outputs('0, '0, '0, '0, '0, '0, "spec empty candidates");
endtask

task automatic test_nonspec_priority();
    reset_dut();
    request_vc(3, 0, 1, 1'b1, 1'b1, '0);
    request_vc(3, 1, 4, 1'b0, 1'b0, 4'b0001);
    settle();
    check_outputs(vc_bit(3, 0), dest_field(3, rel_sel(3, 1)), port_bits_t'(1) << 3,
                  '0, '0, '0, "same input port");
    reset_dut();
    request_vc(0, 1, 2, 1'b0, 1'b0, 4'b0001);
    request_vc(4, 3, 2, 1'b1, 1'b1, '0);
    settle();
    check_outputs(vc_bit(4, 3), dest_field(4, rel_sel(4, 2)), port_bits_t'(1) << 4,
                  '0, '0, '0, "same output port");
endtask

task automatic test_output_rotation();
    int winners [4] = '{0, 2, 0, 2};
    int w;
    reset_dut();
    request_vc(0, 0, 4, 1'b1, 1'b1, '0);
    request_vc(2, 0, 4, 1'b1, 1'b1, '0);
    for (int c = 0; c < 4; c++) begin
        if (c > 0) begin
            next_slot();
        end
        settle();
        w = winners[c];
        check_outputs(vc_bit(w, 0), dest_field(w, rel_sel(w, 4)), port_bits_t'(1) << w,
                      '0, '0, '0, $sformatf("rotation cycle %0d", c));
    end
endtask

task automatic test_random_invariants();
    int       out_hits [`NOC_P];
    int       o_abs;
    all_vc_t  eligible;
    all_vc_t  exp_alloc;
    out_sel_t field;
    reset_dut();
    for (int c = 0; c < 200; c++) begin
        ivc_request           = all_vc_t'(random_bits(`NOC_PV));
        ovc_is_assigned       = all_vc_t'(random_bits(`NOC_PV));
        assigned_ovc_not_full = all_vc_t'(random_bits(`NOC_PV));
        for (int k = 0; k < `NOC_PV; k++) begin
            dest_port[k*`NOC_P_1 +: `NOC_P_1] = out_sel_t'(1) << (random_bits(8) % `NOC_P_1);
            candidate_ovc[k*`NOC_V +: `NOC_V] = port_vc_t'(random_bits(`NOC_V));
        end
        eligible = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
        for (int k = 0; k < `NOC_PV; k++) begin
            if (ivc_request[k] && !ovc_is_assigned[k] && |candidate_ovc[k*`NOC_V +: `NOC_V])
                eligible[k] = 1'b1;
        end
        settle();
        exp_alloc = '0;
        for (int o = 0; o < `NOC_P; o++) begin
            out_hits[o] = 0;
        end
        for (int p = 0; p < `NOC_P; p++) begin
            field = granted_dest_port[p*`NOC_P_1 +: `NOC_P_1];
            check_value($onehot0(field), 1, $sformatf("cycle %0d: one output per input", c));
            check_value($countones(ivc_sw_grant[p*`NOC_V +: `NOC_V]) > 1, 0,
                        $sformatf("cycle %0d: one VC per input port %0d", c, p));
            check_value(port_sw_granted[p], |field, $sformatf("cycle %0d: port_sw_granted", c));
            for (int j = 0; j < `NOC_P_1; j++) begin
                if (field[j]) begin
                    o_abs = abs_out(p, j);
                    out_hits[o_abs]++;
                    exp_alloc[o_abs*`NOC_V +: `NOC_V] =
                        exp_alloc[o_abs*`NOC_V +: `NOC_V] | granted_ovc[p];
                end
            end
        end
        for (int o = 0; o < `NOC_P; o++) begin
            check_value(out_hits[o] > 1, 0, $sformatf("cycle %0d: output %0d shared", c, o));
        end
        for (int k = 0; k < `NOC_PV; k++) begin
            if (ivc_sw_grant[k]) begin
                check_value(eligible[k], 1, $sformatf("cycle %0d: VC %0d not eligible", c, k));
                check_value(dest_port[k*`NOC_P_1 +: `NOC_P_1],
                            granted_dest_port[(k/`NOC_V)*`NOC_P_1 +: `NOC_P_1],
                            $sformatf("cycle %0d: VC %0d destination", c, k));
            end
        end
        check_value(ivc_ovc_grant & ~ivc_sw_grant, 0, $sformatf("cycle %0d: ovc grant", c));
        check_value(ovc_allocated, exp_alloc, $sformatf("cycle %0d: ovc_allocated", c));
        next_slot();
    end
endtask

// File: verification/allocator_tb.sv
`timescale 1ns/1ps
`include "noc_alloc_macros.svh"

module allocator_tb;

    import noc_alloc_pkg::*;

    logic          clk;
    logic          rst_n;
    all_vc_t       ivc_request;
    all_vc_t       ovc_is_assigned;
    all_vc_t       assigned_ovc_not_full;
    dest_all_t     dest_port;
    cand_ovc_all_t candidate_ovc;
    all_vc_t       ivc_sw_grant;
    out_sel_all_t  granted_dest_port;
    port_bits_t    port_sw_granted;
    all_vc_t       ivc_ovc_grant;
    port_vc_t      granted_ovc [`NOC_P];
    all_vc_t       ovc_allocated;

    int          check_count;
    int          mismatch_count;
    int          other_errors;
    logic [31:0] lfsr_state;

    comb_spec_allocator DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .candidate_ovc        (candidate_ovc),
        .ivc_sw_grant         (ivc_sw_grant),
        .granted_dest_port    (granted_dest_port),
        .port_sw_granted      (port_sw_granted),
        .ivc_ovc_grant        (ivc_ovc_grant),
        .granted_ovc          (granted_ovc),
        .ovc_allocated        (ovc_allocated)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form with polynomial x^32+x^22+x^2+x+1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        logic        lsb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            bits[i] = lsb;
        end
        return bits;
    endfunction

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // rising edge plus the drive offset
    task automatic next_slot();
        int polls;
        polls = 0;
        @(clk);
        while (clk !== 1'b1 && polls < 4) begin
            @(clk);
            polls++;
        end
        if (clk !== 1'b1) begin
            other_errors++;
            $display("timed out at %0t ns waiting for a rising clock edge", $time);
            report_and_finish();
        end else begin
            #2;
        end
    endtask

    task automatic settle();
        #26;    // well before the next edge
    endtask

    task automatic clear_inputs();
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        dest_port             = '0;
        candidate_ovc         = '0;
    endtask

    task automatic reset_dut();
        next_slot();
        clear_inputs();
        rst_n = 1'b0;
        repeat (5) next_slot();
        rst_n = 1'b1;
    endtask

    `include "allocator_tests.svh"

    initial begin
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        lfsr_state     = 32'd95307;
        rst_n          = 1'b0;
        clear_inputs();
        test_idle();
        test_nonspec_grant();
        test_spec_grant();
        test_nonspec_priority();
        test_output_rotation();
        test_random_invariants();
        report_and_finish();
    end

endmodule

// File: project.f
+incdir+hw
+incdir+verification
hw/noc_alloc_pkg.sv
hw/rr_arbiter.sv
hw/one_hot_select.sv
hw/switch_alloc_stage.sv
hw/spec_switch_alloc.sv
hw/vc_alloc_stage.sv
hw/comb_spec_allocator.sv
verification/allocator_tb.sv

// File: Bender.yml
package:
  name: comb_spec_allocator

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/noc_alloc_pkg.sv
      - hw/rr_arbiter.sv
      - hw/one_hot_select.sv
      - hw/switch_alloc_stage.sv
      - hw/spec_switch_alloc.sv
      - hw/vc_alloc_stage.sv
      - hw/comb_spec_allocator.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/allocator_tb.sv
